// File: mac_pkg.sv
// Memory address computation, logical side
// Microcode commands, adder operand selects and logical address types

package mac_pkg;

  localparam int LADDR_W  = 16;                // Logical address width
  localparam int MCA_W    = 10;                // In-page address width
  localparam int PAGE_LSB = 10;                // Page number starts here

  typedef logic [LADDR_W-1:0] laddr_t;         // Logical address word
  typedef logic [MCA_W-1:0]   mca_t;           // Word within a 1K page

  // Microcode command field
  typedef enum logic [2:0] {
    CMD_NOP   = 3'd0,                          // Hold everything
    CMD_PX    = 3'd1,                          // P + X
    CMD_PB    = 3'd2,                          // P + B
    CMD_RB    = 3'd3,                          // R + B
    CMD_CD    = 3'd4,                          // Cache data word as address
    CMD_INC   = 3'd5,                          // Current address + 1
    CMD_LDPCR = 3'd6,                          // Load paging control
    CMD_LDSEG = 3'd7                           // Load segment reg, index on cmis
  } mac_cmd_e;

  // Adder operand pair
  typedef enum logic [2:0] {
    SRC_PX  = 3'd0,
    SRC_PB  = 3'd1,
    SRC_RB  = 3'd2,
    SRC_CD  = 3'd3,
    SRC_INC = 3'd4
  } addr_src_e;

endpackage

// File: paging_pkg.sv
// Memory address computation, paging side
// Segment, physical page and paging control definitions

package paging_pkg;

  localparam int SEG_W     = 8;                // Segment register width
  localparam int PAGE_W    = 14;               // Physical page number width
  localparam int PCR_W     = 16;               // Paging control word width
  localparam int SEG_IDX_W = 2;                // Segment index width
  localparam int NUM_SEG   = 4;                // Segment registers

  typedef logic [SEG_W-1:0]     seg_t;         // Segment value
  typedef logic [PAGE_W-1:0]    page_t;        // Physical page
  typedef logic [SEG_IDX_W-1:0] seg_idx_t;     // Segment register index

  // Paging control word, loaded whole from fidbo
  typedef struct packed {
    logic [PCR_W-SEG_IDX_W-1:0] spare;         // Not decoded here
    seg_idx_t                   seg_sel;       // Active segment register
  } pcr_t;

endpackage

// File: mac_ctl_if.sv
// Decoded MAC control
// Operand select and load strobes from the command decoder

`timescale 1ns/10ps

interface mac_ctl_if;

  import mac_pkg::*;
  import paging_pkg::*;

  addr_src_e src;                              // Adder operand pair
  logic      ld_ica;                           // Load address register
  logic      ld_pcr;                           // Load paging control
  logic      ld_seg;                           // Load one segment reg
  seg_idx_t  seg_idx;                          // Which segment reg

  modport decode (output src, ld_ica, ld_pcr, ld_seg, seg_idx);
  modport add    (input src);
  modport ap     (input ld_ica);
  modport segpt  (input ld_pcr, ld_seg, seg_idx);

endinterface

// File: pt_if.sv
// Paging state
// Selected segment and control word toward the page selector

`timescale 1ns/10ps

interface pt_if;

  import paging_pkg::*;

  seg_t     seg;                               // Segment picked by pcr
  logic     segz;                              // That segment is zero
  pcr_t     pcr;                               // Current control word
  seg_idx_t seg_sel;                           // Index in use

  modport segpt (output seg, segz, pcr, seg_sel);
  modport lasel (input seg, segz, pcr, seg_sel);

endinterface

// File: mac_decode.sv
// MAC command decoder
// Turns command and load strobe into operand select and load pulses

`timescale 1ns/10ps

module mac_decode (
  input  logic               ilcs_n,           // Load strobe, active low
  input  mac_pkg::mac_cmd_e  cmd,              // Microcode command
  input  logic [1:0]         cmis,             // Microcode misc, segment index
  mac_ctl_if.decode          ctl
);

  import mac_pkg::*;
  import paging_pkg::*;

  logic ilcs;                                  // Strobe, active high

  assign ilcs = ~ilcs_n;

  always_comb begin
    ctl.src    = SRC_PX;                       // Don't care when idle
    ctl.ld_ica = 1'b0;
    ctl.ld_pcr = 1'b0;
    ctl.ld_seg = 1'b0;
    case (cmd)
      CMD_PX:    begin ctl.src = SRC_PX;  ctl.ld_ica = ilcs; end
      CMD_PB:    begin ctl.src = SRC_PB;  ctl.ld_ica = ilcs; end
      CMD_RB:    begin ctl.src = SRC_RB;  ctl.ld_ica = ilcs; end
      CMD_CD:    begin ctl.src = SRC_CD;  ctl.ld_ica = ilcs; end
      CMD_INC:   begin ctl.src = SRC_INC; ctl.ld_ica = ilcs; end
      CMD_LDPCR: ctl.ld_pcr = ilcs;
      CMD_LDSEG: ctl.ld_seg = ilcs;
      default:   ;                             // NOP holds all
    endcase
  end

  assign ctl.seg_idx = seg_idx_t'(cmis);       // Passed straight on

endmodule

// File: mac_add.sv
// Logical address adder
// Picks the operand pair for the command and forms a wrapping 16-bit sum

`timescale 1ns/10ps

module mac_add (
  mac_ctl_if.add            ctl,
  input  mac_pkg::laddr_t   pr,                // P register
  input  mac_pkg::laddr_t   xr,                // X register
  input  mac_pkg::laddr_t   br,                // B register
  input  mac_pkg::laddr_t   rb,                // R register
  input  mac_pkg::laddr_t   cd,                // Cache data word
  input  mac_pkg::laddr_t   ica,               // Current address
  output mac_pkg::laddr_t   add                // Next logical address
);

  import mac_pkg::*;

  laddr_t opa;
  laddr_t opb;

  always_comb begin
    case (ctl.src)
      SRC_PX:  begin opa = pr;  opb = xr;         end
      SRC_PB:  begin opa = pr;  opb = br;         end
      SRC_RB:  begin opa = rb;  opb = br;         end
      SRC_CD:  begin opa = cd;  opb = '0;         end  // Taken as is
      SRC_INC: begin opa = ica; opb = laddr_t'(1); end
      default: begin opa = '0;  opb = '0;         end
    endcase
  end

  assign add = opa + opb;                      // Carry out dropped

endmodule

// File: mac_ap.sv
// Logical address register
// Holds ica and derives in-page address, next address and page-crossing flag

`timescale 1ns/10ps

module mac_ap (
  input  logic              mclk,
  input  logic              rst_n,
  mac_ctl_if.ap             ctl,
  input  mac_pkg::laddr_t   add,               // From adder
  input  logic              double,            // Double-word access
  output mac_pkg::laddr_t   ica,               // Current logical address
  output mac_pkg::mca_t     mca,               // Word within page
  output mac_pkg::laddr_t   nlca,              // Next sequential address
  output logic              eccr               // Second word in next page
);

  import mac_pkg::*;

  always_ff @(posedge mclk or negedge rst_n) begin
    if (!rst_n) begin
      ica <= '0;
    end else if (ctl.ld_ica) begin
      ica <= add;                              // Only on a strobed address cmd
    end
  end

  assign mca  = ica[PAGE_LSB-1:0];
  assign nlca = ica + laddr_t'(1);             // Wraps at FFFF

  // Last word of a 1K page, so the second half of a double
  // access lands in the next page
  assign eccr = double & (&mca);

endmodule

// File: mac_segpt.sv
// Segment and paging control registers
// PCR plus four segment registers loaded from fidbo, active segment muxed out

`timescale 1ns/10ps

module mac_segpt (
  input  logic              mclk,
  input  logic              rst_n,
  mac_ctl_if.segpt          ctl,
  input  mac_pkg::laddr_t   fidbo,             // Internal data bus
  pt_if.segpt               pt,
  output paging_pkg::pcr_t  pcr                // Paging control word
);

  import paging_pkg::*;

  pcr_t pcr_q;
  seg_t seg_q [NUM_SEG];                       // Segment registers

  always_ff @(posedge mclk or negedge rst_n) begin
    if (!rst_n) begin
      pcr_q <= '0;
    end else if (ctl.ld_pcr) begin
      pcr_q <= pcr_t'(fidbo);                  // Whole word
    end
  end

  always_ff @(posedge mclk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_SEG; i++) begin
        seg_q[i] <= '0;
      end
    end else if (ctl.ld_seg) begin
      seg_q[ctl.seg_idx] <= fidbo[SEG_W-1:0];  // Low byte only
    end
  end

  assign pcr        = pcr_q;
  assign pt.pcr     = pcr_q;
  assign pt.seg_sel = pcr_q.seg_sel;

  // New PCR or segment value is seen by the very next address
  assign pt.seg  = seg_q[pcr_q.seg_sel];
  assign pt.segz = (seg_q[pcr_q.seg_sel] == '0);

endmodule

// File: mac_lasel.sv
// Physical page selector
// Registers the 14-bit page, segment or zero extended, and the violation flag

`timescale 1ns/10ps

module mac_lasel (
  input  logic               mclk,
  input  logic               rst_n,
  input  logic               poni,             // Protection on
  input  mac_pkg::laddr_t    ica,              // Current logical address
  pt_if.lasel                pt,
  output paging_pkg::page_t  la,               // Physical page, bits 23:10
  output logic               vex               // Access through zero segment
);

  import mac_pkg::*;
  import paging_pkg::*;

  page_t page_nxt;
  logic  vex_nxt;

  always_comb begin
    if (poni) begin
      page_nxt = {pt.seg, ica[LADDR_W-1:PAGE_LSB]};       // Segment on top
    end else begin
      page_nxt = {{SEG_W{1'b0}}, ica[LADDR_W-1:PAGE_LSB]}; // Zero extended
    end
  end

  assign vex_nxt = poni & pt.segz;             // Only checked with protection

  // One cycle behind ica, both flags together
  always_ff @(posedge mclk or negedge rst_n) begin
    if (!rst_n) begin
      la  <= '0;
      vex <= 1'b0;
    end else begin
      la  <= page_nxt;
      vex <= vex_nxt;
    end
  end

endmodule

// File: mac_top.sv
// Memory address computation block
// Logical address forming, paging registers and physical page select

`timescale 1ns/10ps

module mac_top (
  input  logic               mclk,             // Master clock
  input  logic               rst_n,
  input  logic               ilcs_n,           // Load strobe, active low
  input  logic               double,           // Double-word access
  input  logic               poni,             // Protection on
  input  mac_pkg::mac_cmd_e  cmd,              // Microcode command
  input  logic [1:0]         cmis,             // Microcode misc
  input  mac_pkg::laddr_t    pr,               // P register
  input  mac_pkg::laddr_t    xr,               // X register
  input  mac_pkg::laddr_t    br,               // B register
  input  mac_pkg::laddr_t    rb,               // R register
  input  mac_pkg::laddr_t    cd,               // Cache data
  input  mac_pkg::laddr_t    fidbo,            // Internal data bus
  output paging_pkg::page_t  la,               // Physical page
  output mac_pkg::mca_t      mca,              // In-page address
  output mac_pkg::laddr_t    nlca,             // Next logical address
  output paging_pkg::pcr_t   pcr,              // Paging control
  output logic               eccr,             // Page crossing on double
  output logic               vex               // Zero segment violation
);

  import mac_pkg::*;

  laddr_t add;                                 // Adder to address reg
  laddr_t ica;                                 // Current logical address

  mac_ctl_if ctl ();
  pt_if      pt ();

  mac_decode u_decode (.ilcs_n(ilcs_n), .cmd(cmd), .cmis(cmis), .ctl(ctl.decode));

  mac_add u_add (
    .ctl(ctl.add), .pr(pr), .xr(xr), .br(br), .rb(rb), .cd(cd), .ica(ica), .add(add)
  );

  mac_ap u_ap (
    .mclk(mclk), .rst_n(rst_n), .ctl(ctl.ap), .add(add), .double(double),
    .ica(ica), .mca(mca), .nlca(nlca), .eccr(eccr)
  );

  mac_segpt u_segpt (
    .mclk(mclk), .rst_n(rst_n), .ctl(ctl.segpt), .fidbo(fidbo), .pt(pt.segpt), .pcr(pcr)
  );

  mac_lasel u_lasel (
    .mclk(mclk), .rst_n(rst_n), .poni(poni), .ica(ica), .pt(pt.lasel),
    .la(la), .vex(vex)
  );

endmodule

// File: tb_mac_tasks.svh
// MAC testbench tasks
// LFSR operands, reference-model clock step, compare tasks and directed tests

`ifndef TB_MAC_TASKS_SVH
`define TB_MAC_TASKS_SVH

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

task automatic rand_word(output laddr_t w);
  w = '0;
  for (int i = 0; i < 16; i++) begin
    lfsr = lfsr_next(lfsr);                    // One step per bit
    w = {w[14:0], lfsr[0]};
  end
endtask

task automatic check_laddr(input string name, input laddr_t got, input laddr_t exp);
  if (got !== exp) begin
    $display("FAIL %0t %s got %h exp %h", $time, name, got, exp);
    errors++;
  end
endtask

task automatic check_mca(input string name, input mca_t got, input mca_t exp);
  if (got !== exp) begin
    $display("FAIL %0t %s got %h exp %h", $time, name, got, exp);
    errors++;
  end
endtask

task automatic check_page(input string name, input page_t got, input page_t exp);
  if (got !== exp) begin
    $display("FAIL %0t %s got %h exp %h", $time, name, got, exp);
    errors++;
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("FAIL %0t %s got %b exp %b", $time, name, got, exp);
    errors++;
  end
endtask

task automatic drive_idle();
  ilcs_n = 1'b1;
  cmd    = CMD_NOP;
endtask

// One clock with the driven inputs; model update, then every output checked
task automatic tick();
  seg_t  sel;
  page_t la_exp;
  logic  vex_exp;
  sel     = seg_m[pcr_m.seg_sel];
  la_exp  = poni ? {sel, ica_m[15:10]} : {8'h00, ica_m[15:10]}; // Page from old ica
  vex_exp = poni && (sel == 8'h00);
  if (!ilcs_n) begin
    case (cmd)
      CMD_PX:    ica_m = pr + xr;
      CMD_PB:    ica_m = pr + br;
      CMD_RB:    ica_m = rb + br;
      CMD_CD:    ica_m = cd;
      CMD_INC:   ica_m = ica_m + 16'd1;
      CMD_LDPCR: pcr_m = pcr_t'(fidbo);
      CMD_LDSEG: seg_m[cmis] = fidbo[7:0];
      default:   ;
    endcase
  end
  @(posedge mclk);
  #5;
  check_mca("mca", mca, ica_m[9:0]);
  check_laddr("nlca", nlca, ica_m + 16'd1);
  check_laddr("pcr", laddr_t'(pcr), laddr_t'(pcr_m));
  check_page("la", la, la_exp);
  check_bit("vex", vex, vex_exp);
  check_bit("eccr", eccr, double & (ica_m[9:0] == 10'h3FF));
endtask

task automatic begin_test();
  test_errors = errors;
  tests_run++;
endtask

task automatic end_test(input string name);
  $display("%s: %0d errors", name, errors - test_errors);
endtask

task automatic issue(input mac_cmd_e c, input logic [1:0] idx, input laddr_t data);
  ilcs_n = 1'b0;
  cmd    = c;
  cmis   = idx;
  fidbo  = data;
  tick();
endtask

task automatic reset_state();
  begin_test();
  check_page("la", la, '0);
  check_mca("mca", mca, '0);
  check_laddr("nlca-1", nlca - 16'd1, '0);
  check_laddr("pcr", laddr_t'(pcr), '0);
  check_bit("vex", vex, 1'b0);
  end_test("reset");
endtask

// Random address commands back to back, protection off
task automatic addr_commands();
  mac_cmd_e kinds [4];
  begin_test();
  kinds = '{CMD_PX, CMD_PB, CMD_RB, CMD_CD};
  poni = 1'b0;
  for (int i = 0; i < 16; i++) begin
    rand_word(pr);
    rand_word(xr);
    rand_word(br);
    rand_word(rb);
    rand_word(cd);
    issue(kinds[i % 4], 2'd0, '0);
  end
  drive_idle();
  tick();
  tick();
  end_test("address commands");
endtask

task automatic inc_wrap_and_hold();
  begin_test();
  cd = 16'hFFFE;
  issue(CMD_CD, 2'd0, '0);
  repeat (3) issue(CMD_INC, 2'd0, '0);         // FFFF, 0000, 0001
  ilcs_n = 1'b1;
  cmd    = CMD_INC;                            // Strobe high holds
  tick();
  tick();
  issue(CMD_NOP, 2'd0, '0);
  issue(CMD_NOP, 2'd0, '0);
  drive_idle();
  tick();
  end_test("increment and hold");
endtask

// All segments and PCR loaded, then addresses through each segment
task automatic segment_paging();
  laddr_t w;
  begin_test();
  poni = 1'b1;
  for (int s = 0; s < NUM_SEG; s++) begin
    rand_word(w);
    w[0] = 1'b1;                               // Keep it nonzero
    issue(CMD_LDSEG, 2'(s), w);
  end
  for (int s = 0; s < NUM_SEG; s++) begin
    rand_word(w);
    w[1:0] = 2'(s);
    issue(CMD_LDPCR, 2'd0, w);
    rand_word(cd);
    issue(CMD_CD, 2'd0, '0);                   // First address after new PCR
  end
  drive_idle();
  tick();
  tick();
  end_test("segments");
endtask

task automatic zero_segment_vex();
  begin_test();
  poni = 1'b1;
  issue(CMD_LDSEG, 2'd3, 16'hAB00);           // Low byte zero
  issue(CMD_LDPCR, 2'd0, 16'h0003);
  cd = 16'h5555;
  issue(CMD_CD, 2'd0, '0);
  drive_idle();
  tick();
  tick();
  poni = 1'b0;
  tick();
  tick();
  poni = 1'b1;
  issue(CMD_LDPCR, 2'd0, 16'h0001);
  drive_idle();
  tick();
  tick();
  end_test("violation");
endtask

task automatic page_crossing();
  begin_test();
  poni   = 1'b0;
  double = 1'b1;
  cd     = 16'h13FF;
  issue(CMD_CD, 2'd0, '0);
  double = 1'b0;
  drive_idle();
  tick();
  double = 1'b1;
  tick();
  cd = 16'h1234;
  issue(CMD_CD, 2'd0, '0);
  drive_idle();
  tick();
  double = 1'b0;
  tick();
  end_test("page crossing");
endtask

`endif

// File: tb_mac.sv
// Testbench for the memory address computation block
// Clock, reset, watchdog, operand LFSR and the directed test sequence

`timescale 1ns/10ps

module tb_mac;

  import mac_pkg::*;
  import paging_pkg::*;

  localparam int  CLK_PERIOD  = 100;           // ns
  localparam int  RESET_CYC   = 8;
  localparam int  TEST_CYCLES = RESET_CYC + 90; // Sum over all tests, rounded up
  localparam int  WATCHDOG_NS = TEST_CYCLES * CLK_PERIOD + 2000;

  logic      mclk;
  logic      rst_n;
  logic      ilcs_n;
  logic      double;
  logic      poni;
  mac_cmd_e  cmd;
  logic [1:0] cmis;
  laddr_t    pr;
  laddr_t    xr;
  laddr_t    br;
  laddr_t    rb;
  laddr_t    cd;
  laddr_t    fidbo;
  page_t     la;
  mca_t      mca;
  laddr_t    nlca;
  pcr_t      pcr;
  logic      eccr;
  logic      vex;

  // Reference model of the block state
  laddr_t    ica_m;
  seg_t      seg_m [NUM_SEG];
  pcr_t      pcr_m;

  logic [15:0] lfsr;                           // Operand generator state
  int          errors;
  int          test_errors;                    // Error count at test start
  int          tests_run;

  mac_top dut (
    .mclk(mclk), .rst_n(rst_n), .ilcs_n(ilcs_n), .double(double), .poni(poni),
    .cmd(cmd), .cmis(cmis), .pr(pr), .xr(xr), .br(br), .rb(rb), .cd(cd),
    .fidbo(fidbo), .la(la), .mca(mca), .nlca(nlca), .pcr(pcr), .eccr(eccr),
    .vex(vex)
  );

  `include "tb_mac_tasks.svh"

  initial begin
    mclk = 1'b0;
    forever #(CLK_PERIOD / 2) mclk = ~mclk;
  end

  // Ends a run that got stuck
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the test sequence finished");
    $display("Checks failed");
    $finish;
  end

  initial begin
    rst_n  = 1'b0;
    ilcs_n = 1'b1;
    double = 1'b0;
    poni   = 1'b0;
    cmd    = CMD_NOP;
    cmis   = 2'd0;
    pr     = '0;
    xr     = '0;
    br     = '0;
    rb     = '0;
    cd     = '0;
    fidbo  = '0;
    lfsr   = 16'd86;                           // Seed
    errors = 0;
    tests_run = 0;
    ica_m  = '0;
    pcr_m  = '0;
    for (int i = 0; i < NUM_SEG; i++) begin
      seg_m[i] = '0;
    end
    repeat (RESET_CYC) @(posedge mclk);
    #5;
    rst_n = 1'b1;

    reset_state();
    addr_commands();
    inc_wrap_and_hold();
    segment_paging();
    zero_segment_vex();
    page_crossing();

    $display("Tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+.
mac_pkg.sv
paging_pkg.sv
mac_ctl_if.sv
pt_if.sv
mac_decode.sv
mac_add.sv
mac_ap.sv
mac_segpt.sv
mac_lasel.sv
mac_top.sv
tb_mac.sv

// File: run.sh
#!/bin/sh
# Build and run the MAC testbench with Verilator
verilator --binary --timing -f sources.f --top-module tb_mac -o tb_mac_sim \
  && ./obj_dir/tb_mac_sim | tee /dev/stderr | grep -q "All checks passed" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
